//--- run.sh
#!/usr/bin/env bash
# builds and runs the resultSelect testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module resultSelectTb -f verilog.f -o resultSelectSim

./obj_dir/resultSelectSim 2>&1 | tee sim.log

if grep -qx "No errors" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

//--- source/cvtIntPkg.sv
package cvtIntPkg;

    //////////////////////////////////////////////////////////////////////
    // rounding modes
    //////////////////////////////////////////////////////////////////////

    // same encoding as the frm csr field
    typedef enum logic [2:0] {
        rne = 3'b000,    // nearest, ties to even
        rtz = 3'b001,    // toward zero
        rdn = 3'b010,    // toward minus infinity
        rup = 3'b011,    // toward plus infinity
        rmm = 3'b100     // nearest, ties to max magnitude
    } roundMode_t;

    //////////////////////////////////////////////////////////////////////
    // 32-bit integer results
    //////////////////////////////////////////////////////////////////////

    localparam int int32Len = 32;

    typedef logic [int32Len-1:0] int32_t;

    // saturation values for signed word results
    localparam int32_t int32Min = 32'h8000_0000;
    localparam int32_t int32Max = 32'h7fff_ffff;

endpackage

//--- source/fpFormatPkg.sv
package fpFormatPkg;

    //////////////////////////////////////////////////////////////////////
    // format widths
    //////////////////////////////////////////////////////////////////////

    localparam int flen = 64;            // widest register value
    localparam int doubleNe = 11;
    localparam int doubleNf = 52;
    localparam int singleNe = 8;
    localparam int singleNf = 23;
    localparam int singleLen = 32;

    // shifted mantissa out of the normalization shifter
    localparam int normShiftSz = 168;

    //////////////////////////////////////////////////////////////////////
    // vector types
    //////////////////////////////////////////////////////////////////////

    typedef logic [flen-1:0] flen_t;         // full register value

    typedef logic [doubleNe-1:0] exp_t;      // biased exponent

    // two extra msbs flag underflow and overflow
    typedef logic [doubleNe+1:0] fullExp_t;

    // top bit set means the conversion underflowed
    typedef logic [doubleNe:0] cvtExp_t;

    typedef logic [doubleNf-1:0] frac_t;     // fraction only
    typedef logic [doubleNf:0] man_t;        // with hidden bit

    typedef logic [flen:0] roundAdd_t;       // round increment

    //////////////////////////////////////////////////////////////////////
    // output format
    //////////////////////////////////////////////////////////////////////

    // encoded as in the instruction fmt field
    typedef enum logic {
        fmtSingle = 1'b0,
        fmtDouble = 1'b1
    } fmt_t;

endpackage

//--- source/fpResultPriority.sv
`timescale 1ns/100ps

module fpResultPriority
    import fpFormatPkg::*;
(
    input  flen_t    xNaNRes,
    input  flen_t    yNaNRes,
    input  flen_t    zNaNRes,
    input  flen_t    invalidRes,
    input  flen_t    ofRes,
    input  flen_t    killProdRes,
    input  flen_t    ufRes,
    input  flen_t    normRes,
    input  logic     xNaN,
    input  logic     yNaN,
    input  logic     zNaN,
    input  logic     invalid,       // invalid flag
    input  logic     overflow,
    input  logic     divByZero,
    input  logic     infIn,
    input  logic     killProd,      // product too small to matter
    input  logic     fmaOp,
    input  logic     cvtOp,
    input  logic     intToFp,
    input  logic     cvtResUf,      // conversion underflow
    input  logic     xZero,
    input  logic     intZero,
    input  fullExp_t fullResExp,
    output flen_t    postProcRes
);

    logic killRes;

    // conversions only kill on a zero of the operand actually in use
    assign killRes = cvtOp ? (cvtResUf | (xZero & ~intToFp) | (intZero & intToFp))
                           : fullResExp[doubleNe+1];

    //////////////////////////////////////////////////////////////////////
    // priority select
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        if (xNaN & ~(intToFp & cvtOp)) begin
            postProcRes = xNaNRes;
        end else if (yNaN & ~cvtOp) begin
            postProcRes = yNaNRes;
        end else if (zNaN & fmaOp) begin
            postProcRes = zNaNRes;
        end else if (invalid) begin
            postProcRes = invalidRes;
        end else if (overflow | divByZero | infIn) begin
            postProcRes = ofRes;            // signed infinity or max finite
        end else if (killProd & fmaOp) begin
            postProcRes = killProdRes;
        end else if (killRes) begin
            postProcRes = ufRes;
        end else begin
            postProcRes = normRes;
        end
    end

endmodule

//--- source/intCvtResult.sv
`timescale 1ns/100ps

module intCvtResult
    import fpFormatPkg::*;
    import cvtIntPkg::*;
#(
    parameter int Xlen = 64
) (
    input  logic                   xSgn,
    input  logic                   xNaN,
    input  logic                   isSigned,
    input  logic                   int64,       // long result, low when Xlen is 32
    input  logic                   plus1,
    input  logic                   intInvalid,  // out of range, nan or infinity
    input  logic [normShiftSz-1:0] shifted,
    input  cvtExp_t                cvtCalcExp,
    output logic [Xlen-1:0]        fCvtIntRes,
    output logic [1:0]             negResMsbs
);

    logic [Xlen+1:0] roundedRes;    // magnitude after rounding
    logic [Xlen+1:0] negRes;        // signed result with two guard bits
    logic [Xlen-1:0] ofIntRes;      // saturation value
    logic            negIn;         // negative and not a nan
    logic            cvtUf;

    assign negIn = xSgn & ~xNaN;
    assign cvtUf = cvtCalcExp[doubleNe];

    //////////////////////////////////////////////////////////////////////
    // round and negate
    //////////////////////////////////////////////////////////////////////

    assign roundedRes = {2'b00, shifted[normShiftSz-1 -: Xlen]} + {{Xlen+1{1'b0}}, plus1};
    assign negRes = xSgn ? -roundedRes : roundedRes;

    // bits on either side of the destination's sign position
    always_comb begin
        if (isSigned) begin
            negResMsbs = int64 ? negRes[Xlen:Xlen-1] : negRes[int32Len:int32Len-1];
        end else begin
            negResMsbs = int64 ? negRes[Xlen+1:Xlen] : negRes[int32Len+1:int32Len];
        end
    end

    //////////////////////////////////////////////////////////////////////
    // saturation
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        if (isSigned) begin
            if (negIn) begin
                ofIntRes = int64 ? {1'b1, {Xlen-1{1'b0}}}
                                 : Xlen'($signed(int32Min));  // sign extended word min
            end else begin
                ofIntRes = int64 ? {1'b0, {Xlen-1{1'b1}}} : Xlen'(int32Max);
            end
        end else begin
            ofIntRes = negIn ? '0 : '1;    // unsigned clamps to 0 or all ones
        end
    end

    //////////////////////////////////////////////////////////////////////
    // final select
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        if (intInvalid) begin
            fCvtIntRes = ofIntRes;
        end else if (cvtUf) begin
            // magnitude below one rounds to 0, 1 or -1
            fCvtIntRes = (xSgn & isSigned & plus1) ? '1 : Xlen'(plus1);
        end else if (int64) begin
            fCvtIntRes = negRes[Xlen-1:0];
        end else begin
            fCvtIntRes = Xlen'($signed(negRes[int32Len-1:0]));  // words are sign extended
        end
    end

endmodule

//--- source/resultSelect.sv
`timescale 1ns/100ps

module resultSelect
    import fpFormatPkg::*;
    import cvtIntPkg::*;
#(
    parameter int Xlen = 64
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   inValid,
    input  fmt_t                   outFmt,
    input  roundMode_t             frm,
    input  logic                   resSgn,
    input  logic                   infIn,
    input  logic                   intToFp,
    input  logic                   cvtOp,
    input  logic                   fmaOp,
    input  logic                   plus1,
    input  logic                   addendSticky,
    input  logic                   zDenorm,
    input  logic                   zZero,
    input  man_t                   xMan,
    input  man_t                   yMan,
    input  man_t                   zMan,
    input  exp_t                   zExp,
    input  exp_t                   resExp,
    input  frac_t                  resFrac,
    input  roundAdd_t              roundAdd,
    input  logic                   xNaN,
    input  logic                   yNaN,
    input  logic                   zNaN,
    input  logic                   invalid,
    input  logic                   overflow,
    input  logic                   divByZero,
    input  logic                   killProd,
    input  logic                   cvtResUf,
    input  logic                   xZero,
    input  logic                   intZero,
    input  fullExp_t               fullResExp,
    input  logic                   xSgn,
    input  logic                   isSigned,
    input  logic                   int64,
    input  logic                   intInvalid,
    input  logic [normShiftSz-1:0] shifted,
    input  cvtExp_t                cvtCalcExp,
    output logic                   outValid,
    output flen_t                  postProcRes,
    output logic [Xlen-1:0]        fCvtIntRes,
    output logic [1:0]             negResMsbs
);

    flen_t xNaNRes, yNaNRes, zNaNRes, invalidRes;   // candidates
    flen_t ofRes, killProdRes, ufRes, normRes;
    flen_t           postProcNext;
    logic [Xlen-1:0] fCvtIntNext;
    logic [1:0]      negMsbsNext;

    //////////////////////////////////////////////////////////////////////
    // floating-point path
    //////////////////////////////////////////////////////////////////////

    specialResultGen u_specialResultGen (
        .outFmt, .frm, .resSgn, .infIn, .intToFp, .cvtOp, .plus1,
        .addendSticky, .zDenorm, .zZero, .xMan, .yMan, .zMan, .zExp,
        .resExp, .resFrac, .roundAdd,
        .xNaNRes, .yNaNRes, .zNaNRes, .invalidRes, .ofRes, .killProdRes,
        .ufRes, .normRes
    );

    fpResultPriority u_fpResultPriority (
        .xNaNRes, .yNaNRes, .zNaNRes, .invalidRes, .ofRes, .killProdRes,
        .ufRes, .normRes, .xNaN, .yNaN, .zNaN, .invalid, .overflow,
        .divByZero, .infIn, .killProd, .fmaOp, .cvtOp, .intToFp, .cvtResUf,
        .xZero, .intZero, .fullResExp,
        .postProcRes (postProcNext)
    );

    // integer conversion runs alongside
    intCvtResult #(.Xlen(Xlen)) u_intCvtResult (
        .xSgn, .xNaN, .isSigned, .int64, .plus1, .intInvalid, .shifted, .cvtCalcExp,
        .fCvtIntRes (fCvtIntNext),
        .negResMsbs (negMsbsNext)
    );

    //////////////////////////////////////////////////////////////////////
    // output stage
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            outValid    <= 1'b0;
            postProcRes <= '0;
            fCvtIntRes  <= '0;
            negResMsbs  <= '0;
        end else begin
            outValid <= inValid;
            if (inValid) begin           // hold the last result otherwise
                postProcRes <= postProcNext;
                fCvtIntRes  <= fCvtIntNext;
                negResMsbs  <= negMsbsNext;
            end
        end
    end

endmodule

//--- source/specialResultGen.sv
`timescale 1ns/100ps

module specialResultGen
    import fpFormatPkg::*;
    import cvtIntPkg::*;
(
    input  fmt_t       outFmt,
    input  roundMode_t frm,
    input  logic       resSgn,
    input  logic       infIn,        // an input is infinite
    input  logic       intToFp,
    input  logic       cvtOp,
    input  logic       plus1,        // round up by one ulp
    input  logic       addendSticky,
    input  logic       zDenorm,
    input  logic       zZero,
    input  man_t       xMan,
    input  man_t       yMan,
    input  man_t       zMan,
    input  exp_t       zExp,
    input  exp_t       resExp,
    input  frac_t      resFrac,
    input  roundAdd_t  roundAdd,
    output flen_t      xNaNRes,
    output flen_t      yNaNRes,
    output flen_t      zNaNRes,
    output flen_t      invalidRes,
    output flen_t      ofRes,
    output flen_t      killProdRes,
    output flen_t      ufRes,
    output flen_t      normRes
);

    localparam int boxLen = flen - singleLen;         // nan-box width
    localparam int fracLo = doubleNf - singleNf;      // lsb of single fraction in a man_t
    localparam int addHi = fracLo + singleLen - 2;    // top round bit for single

    logic ofResMax;    // overflow gives largest finite instead of infinity
    logic ufInc;       // underflow rounds up to the smallest denormal
    logic zExpLsb;     // denormal or zero addend has a stored exponent of 0

    // quiet nan carrying the operand's upper fraction bits
    function automatic flen_t quietNaN(input fmt_t fmt, input man_t man);
        flen_t res;
        if (fmt == fmtDouble) begin
            res = {1'b0, {doubleNe{1'b1}}, 1'b1, man[doubleNf-2:0]};
        end else begin
            res = {{boxLen{1'b1}}, 1'b0, {singleNe{1'b1}}, 1'b1, man[doubleNf-2:fracLo]};
        end
        return res;
    endfunction

    assign ofResMax = (~infIn | (intToFp & cvtOp)) &
                      ((frm == rtz) | ((frm == rdn) & ~resSgn) | ((frm == rup) & resSgn));
    assign ufInc = plus1 & frm[1];
    assign zExpLsb = zExp[0] & ~(zDenorm | zZero);

    //////////////////////////////////////////////////////////////////////
    // nan candidates
    //////////////////////////////////////////////////////////////////////

    assign xNaNRes = quietNaN(outFmt, xMan);
    assign yNaNRes = quietNaN(outFmt, yMan);
    assign zNaNRes = quietNaN(outFmt, zMan);
    assign invalidRes = quietNaN(outFmt, '0);   // default nan has an empty payload

    //////////////////////////////////////////////////////////////////////
    // overflow, kill product, underflow, normal
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        if (outFmt == fmtDouble) begin
            ofRes = ofResMax ? {resSgn, {doubleNe-1{1'b1}}, 1'b0, {doubleNf{1'b1}}}
                             : {resSgn, {doubleNe{1'b1}}, {doubleNf{1'b0}}};
            // addend passes through with its rounding applied
            killProdRes = {resSgn, {zExp[doubleNe-1:1], zExpLsb, zMan[doubleNf-1:0]}
                          + (roundAdd[flen-2:0] & {flen-1{addendSticky}})};
            ufRes = {resSgn, {flen-1{1'b0}}} + {{flen-1{1'b0}}, ufInc};
            normRes = {resSgn, resExp, resFrac};
        end else begin
            ofRes = ofResMax ? {{boxLen{1'b1}}, resSgn, {singleNe-1{1'b1}}, 1'b0,
                                {singleNf{1'b1}}}
                             : {{boxLen{1'b1}}, resSgn, {singleNe{1'b1}}, {singleNf{1'b0}}};
            // exponent msb kept, lower bits from the rebiased field
            killProdRes = {{boxLen{1'b1}}, resSgn,
                           {zExp[doubleNe-1], zExp[singleNe-2:1], zExpLsb,
                            zMan[doubleNf-1:fracLo]}
                           + (roundAdd[addHi:fracLo] & {singleLen-1{addendSticky}})};
            ufRes = {{boxLen{1'b1}},
                     {resSgn, {singleLen-1{1'b0}}} + {{singleLen-1{1'b0}}, ufInc}};
            normRes = {{boxLen{1'b1}}, resSgn, resExp[singleNe-1:0],
                       resFrac[doubleNf-1:fracLo]};
        end
    end

endmodule

//--- tb/resultSelectTb.sv
`timescale 1ns/100ps

module resultSelectTb
    import fpFormatPkg::*;
    import cvtIntPkg::*;
();

    localparam int Xlen = 64;
    localparam int timeoutCycles = 20;    // drain limit once stimulus is done

    logic                   clk, rst, inValid;
    fmt_t                   outFmt;
    roundMode_t             frm;
    logic                   resSgn, infIn, intToFp, cvtOp, fmaOp, plus1;
    logic                   addendSticky, zDenorm, zZero;
    man_t                   xMan, yMan, zMan;
    exp_t                   zExp, resExp;
    frac_t                  resFrac;
    roundAdd_t              roundAdd;
    logic                   xNaN, yNaN, zNaN, invalid, overflow, divByZero;
    logic                   killProd, cvtResUf, xZero, intZero;
    fullExp_t               fullResExp;
    logic                   xSgn, isSigned, int64, intInvalid;
    logic [normShiftSz-1:0] shifted;
    cvtExp_t                cvtCalcExp;
    logic                   outValid;
    flen_t                  postProcRes;
    logic [Xlen-1:0]        fCvtIntRes;
    logic [1:0]             negResMsbs;

    logic [31:0]     seed = 32'hddd6_cb94;
    flen_t           expFp[$];      // expected results in issue order
    logic [Xlen-1:0] expInt[$];
    logic [1:0]      expMsbs[$];

    resultSelect #(.Xlen(Xlen)) u_resultSelect (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] lcgNext();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    function automatic logic [63:0] rand64();
        return {lcgNext(), lcgNext()};
    endfunction

    //////////////////////////////////////////////////////////////////////
    // reference model
    //////////////////////////////////////////////////////////////////////

    // single results keep the top fraction bits and sit in a box of ones
    function automatic flen_t packFp(input logic s, input exp_t e, input frac_t f);
        if (outFmt == fmtDouble) begin
            return {s, e, f};
        end
        return {32'hffff_ffff, s, e[singleNe-1:0], f[doubleNf-1:doubleNf-singleNf]};
    endfunction

    function automatic flen_t overflowModel();
        logic maxFinite;
        maxFinite = (!infIn || (intToFp && cvtOp)) &&
                    (frm == rtz || (frm == rdn && !resSgn) || (frm == rup && resSgn));
        return maxFinite ? packFp(resSgn, 11'h7fe, '1) : packFp(resSgn, '1, '0);
    endfunction

    function automatic flen_t killProdModel();
        exp_t                 ze;
        logic [flen-2:0]      dblSum;
        logic [singleLen-2:0] sglSum;
        ze = zExp;
        if (zDenorm || zZero) begin
            ze[0] = 1'b0;    // stored exponent of a tiny addend
        end
        dblSum = {ze, zMan[doubleNf-1:0]} + (addendSticky ? roundAdd[flen-2:0] : '0);
        sglSum = {ze[doubleNe-1], ze[singleNe-2:0], zMan[doubleNf-1:doubleNf-singleNf]}
                 + (addendSticky ? roundAdd[doubleNf-singleNf+singleLen-2:doubleNf-singleNf]
                                 : '0);
        if (outFmt == fmtDouble) begin
            return {resSgn, dblSum};
        end
        return {32'hffff_ffff, resSgn, sglSum};
    endfunction

    function automatic flen_t expectedFp();
        logic  kill;
        frac_t ulp;
        kill = cvtOp ? (cvtResUf || (xZero && !intToFp) || (intZero && intToFp))
                     : fullResExp[doubleNe+1];
        ulp = (outFmt == fmtDouble) ? 52'd1 : 52'd1 << (doubleNf - singleNf);
        if (xNaN && !(intToFp && cvtOp)) return packFp(1'b0, '1, {1'b1, xMan[doubleNf-2:0]});
        if (yNaN && !cvtOp) return packFp(1'b0, '1, {1'b1, yMan[doubleNf-2:0]});
        if (zNaN && fmaOp) return packFp(1'b0, '1, {1'b1, zMan[doubleNf-2:0]});
        if (invalid) return packFp(1'b0, '1, {1'b1, {doubleNf-1{1'b0}}});
        if (overflow || divByZero || infIn) return overflowModel();
        if (killProd && fmaOp) return killProdModel();
        if (kill) return packFp(resSgn, '0, (plus1 && frm[1]) ? ulp : '0);
        return packFp(resSgn, resExp, resFrac);
    endfunction

    function automatic void intModel(output logic [Xlen-1:0] res, output logic [1:0] msbs);
        logic [Xlen+1:0] mag;
        logic [Xlen+1:0] val;
        logic            negIn;
        mag = {2'b00, shifted[normShiftSz-1 -: Xlen]} + {{Xlen+1{1'b0}}, plus1};
        val = xSgn ? ~mag + (Xlen+2)'(1) : mag;    // two's complement
        negIn = xSgn && !xNaN;
        if (isSigned) begin
            msbs = int64 ? val[Xlen:Xlen-1] : val[32:31];
        end else begin
            msbs = int64 ? val[Xlen+1:Xlen] : val[33:32];
        end
        if (intInvalid) begin
            if (!isSigned) begin
                res = negIn ? '0 : '1;
            end else if (int64) begin
                res = negIn ? 64'h8000_0000_0000_0000 : 64'h7fff_ffff_ffff_ffff;
            end else begin
                res = negIn ? 64'hffff_ffff_8000_0000 : 64'h0000_0000_7fff_ffff;
            end
        end else if (cvtCalcExp[doubleNe]) begin
            res = (xSgn && isSigned && plus1) ? '1 : {{Xlen-1{1'b0}}, plus1};
        end else if (int64) begin
            res = val[Xlen-1:0];
        end else begin
            res = {{32{val[31]}}, val[31:0]};
        end
    endfunction

    //////////////////////////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////////////////////////

    // random operand fields with every special flag cleared
    task automatic randomOperands();
        logic [31:0] r;
        xMan = man_t'(rand64());
        yMan = man_t'(rand64());
        zMan = man_t'(rand64());
        zExp = exp_t'(lcgNext());
        resExp = exp_t'(lcgNext());
        resFrac = frac_t'(rand64());
        roundAdd = {1'b0, rand64()};
        shifted = normShiftSz'({rand64(), rand64(), rand64()});
        fullResExp = {1'b0, 12'(lcgNext())};
        cvtCalcExp = {1'b0, 11'(lcgNext())};
        r = lcgNext();
        resSgn = r[0];
        xSgn = r[1];
        plus1 = r[2];
        outFmt = fmt_t'(r[3]);
        frm = roundMode_t'(3'(r[7:4] % 5));
        isSigned = r[8];
        int64 = r[9];
        addendSticky = r[10];
        zDenorm = r[11] & r[12];
        zZero = r[13] & r[14];
        {xNaN, yNaN, zNaN, invalid, overflow, divByZero, infIn, killProd} = '0;
        {fmaOp, cvtOp, intToFp, cvtResUf, xZero, intZero, intInvalid} = '0;
    endtask

    // issue one item at the falling edge and sometimes leave an idle cycle after it
    task automatic sendItem();
        logic [Xlen-1:0] ei;
        logic [1:0]      em;
        logic [31:0]     r;
        intModel(ei, em);
        expFp.push_back(expectedFp());
        expInt.push_back(ei);
        expMsbs.push_back(em);
        inValid = 1'b1;
        @(negedge clk);
        inValid = 1'b0;
        randomOperands();    // new inputs while idle must not be captured
        r = lcgNext();
        if (r[1:0] == 2'b00) begin
            @(negedge clk);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // checking
    //////////////////////////////////////////////////////////////////////

    validFollows: assert property (@(posedge clk) disable iff (rst) inValid |=> outValid)
        else begin
            $display("Error at %0t: outValid expected 1 actual %b", $time, outValid);
            $display("Errors found");
            $fatal(1);
        end

    validDrops: assert property (@(posedge clk) disable iff (rst) !inValid |=> !outValid)
        else begin
            $display("Error at %0t: outValid expected 0 actual %b", $time, outValid);
            $display("Errors found");
            $fatal(1);
        end

    resultsHold: assert property (@(posedge clk) disable iff (rst)
            !inValid |=> $stable(postProcRes) && $stable(fCvtIntRes) && $stable(negResMsbs))
        else begin
            $display("results changed at %0t while inValid was low", $time);
            $display("Errors found");
            $fatal(1);
        end

    // outputs of a freshly reset DUT are all zero
    task automatic checkResetValues();
        assert (outValid === 1'b0) else begin
            $display("Error at %0t: outValid expected 0 actual %b", $time, outValid);
            $display("Errors found");
            $fatal(1);
        end
        assert (postProcRes === '0) else begin
            $display("Error at %0t: postProcRes expected 0 actual %h", $time, postProcRes);
            $display("Errors found");
            $fatal(1);
        end
        assert (fCvtIntRes === '0) else begin
            $display("Error at %0t: fCvtIntRes expected 0 actual %h", $time, fCvtIntRes);
            $display("Errors found");
            $fatal(1);
        end
        assert (negResMsbs === '0) else begin
            $display("Error at %0t: negResMsbs expected 0 actual %b", $time, negResMsbs);
            $display("Errors found");
            $fatal(1);
        end
    endtask

    always @(negedge clk) begin : checkOutputs
        flen_t           ef;
        logic [Xlen-1:0] ei;
        logic [1:0]      em;
        if (!rst && outValid) begin
            if (expFp.size() == 0) begin
                $display("outValid was high at %0t with no item in flight", $time);
                $display("Errors found");
                $fatal(1);
            end else begin
                ef = expFp.pop_front();
                ei = expInt.pop_front();
                em = expMsbs.pop_front();
                assert (postProcRes === ef) else begin
                    $display("Error at %0t: postProcRes expected %h actual %h", $time, ef,
                             postProcRes);
                    $display("Errors found");
                    $fatal(1);
                end
                assert (fCvtIntRes === ei) else begin
                    $display("Error at %0t: fCvtIntRes expected %h actual %h", $time, ei,
                             fCvtIntRes);
                    $display("Errors found");
                    $fatal(1);
                end
                assert (negResMsbs === em) else begin
                    $display("Error at %0t: negResMsbs expected %b actual %b", $time, em,
                             negResMsbs);
                    $display("Errors found");
                    $fatal(1);
                end
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // test sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        int          waitCount;
        logic [31:0] r;
        rst = 1'b1;
        inValid = 1'b1;    // items offered during reset must be dropped
        randomOperands();
        repeat (4) @(posedge clk);
        @(negedge clk);
        inValid = 1'b0;
        checkResetValues();
        @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        checkResetValues();

        for (int i = 0; i < 48; i++) begin    // nan priority
            randomOperands();
            r = lcgNext();
            {xNaN, yNaN, zNaN, invalid, fmaOp, intToFp, overflow} = r[6:0];
            cvtOp = r[7] & r[8];
            sendItem();
        end

        // every rounding mode, sign and cause of an overflow result
        for (int f = 0; f < 2; f++) begin
            for (int m = 0; m < 5; m++) begin
                for (int s = 0; s < 2; s++) begin
                    for (int k = 0; k < 4; k++) begin
                        randomOperands();
                        outFmt = fmt_t'(1'(f));
                        frm = roundMode_t'(3'(m));
                        resSgn = s[0];
                        overflow = (k == 0);
                        divByZero = (k == 1);
                        infIn = (k >= 2);
                        cvtOp = (k == 3);
                        intToFp = (k == 3);
                        sendItem();
                    end
                end
            end
        end

        for (int i = 0; i < 60; i++) begin    // kill product, underflow, normal
            randomOperands();
            r = lcgNext();
            case (r[1:0])
                2'd0: begin
                    fmaOp = 1'b1;
                    killProd = 1'b1;
                end
                2'd1: fullResExp[doubleNe+1] = 1'b1;
                2'd2: {cvtOp, intToFp, cvtResUf, xZero, intZero} = {1'b1, r[5:2]};
                default: ;
            endcase
            sendItem();
        end

        for (int c = 0; c < 32; c++) begin    // saturation and underflow corners
            randomOperands();
            {isSigned, int64, xSgn} = 3'(c);
            if (c[4]) begin
                intInvalid = 1'b1;
                xNaN = c[3];
            end else begin
                cvtCalcExp[doubleNe] = 1'b1;
                plus1 = c[3];
            end
            sendItem();
        end

        for (int i = 0; i < 64; i++) begin    // mixed integer results
            randomOperands();
            r = lcgNext();
            xNaN = r[0] & r[1];
            intInvalid = r[2] & r[3];
            cvtCalcExp[doubleNe] = r[4] & r[5];
            if (r[6]) begin
                shifted[normShiftSz-1 -: 34] = '0;    // magnitude fits a word
            end
            sendItem();
        end

        waitCount = 0;
        while (expFp.size() != 0 && waitCount < timeoutCycles) begin
            @(negedge clk);
            waitCount++;
        end
        if (expFp.size() == 0) begin
            $display("No errors");
            $finish;
        end else begin
            $display("timed out with %0d results still pending", expFp.size());
            $display("Errors found");
            $fatal(1);
        end
    end

endmodule

//--- verilog.f
source/fpFormatPkg.sv
source/cvtIntPkg.sv
source/specialResultGen.sv
source/fpResultPriority.sv
source/intCvtResult.sv
source/resultSelect.sv
tb/resultSelectTb.sv
